//--- hw/dq_capture_ring.sv
`timescale 1ns/100ps

module dq_capture_ring (
   input  logic                   clk,
   input  logic                   rst,
   // Byte arriving from the pad
   input  dq_lane_pkg::lane_byte_t to_core,
   // DQS edge qualifiers, one cycle each
   input  logic                   dqs_rise,
   input  logic                   dqs_fall,
   // Shaped pad enable window
   input  logic                   rd_window,
   input  logic                   burst_length_four,
   // Core read counts for the two rings
   input  dq_lane_pkg::ring_ptr_t  pos_cnt,
   input  dq_lane_pkg::ring_ptr_t  neg_cnt,
   output dq_lane_pkg::rd_result_t rd_result
);

   import dq_lane_pkg::*;

   // Capture pointer and its next value
   ring_ptr_t  cap_ptr;
   ring_ptr_t  cap_ptr_nxt;
   logic       ptr_open;

   // Rising and falling capture rings
   lane_byte_t ring_pos [RING_DEPTH];
   lane_byte_t ring_neg [RING_DEPTH];

   // Entries named by the read counts
   ring_ptr_t  pos_sel;
   ring_ptr_t  neg_sel;

   ////////////////////////////////////////////////////////////////////////////
   // Capture pointer
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      // Burst of four closes on even entries unless the window is open
      if (burst_length_four) begin
         ptr_open = rd_window | cap_ptr[0];
      end else begin
         // Burst of eight runs on until the pointer wraps to zero
         ptr_open = rd_window | (cap_ptr != '0);
      end
      cap_ptr_nxt = cap_ptr;
      if (dqs_fall && ptr_open) begin
         cap_ptr_nxt = cap_ptr + ring_ptr_t'(1);
      end
   end

   // Pointer moves only on the falling DQS edge
   always_ff @(posedge clk) begin
      if (rst) begin
         cap_ptr <= '0;
      end else begin
         cap_ptr <= cap_ptr_nxt;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Capture rings
   ////////////////////////////////////////////////////////////////////////////

   // Both rings write at the current pointer, falling before it moves
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < RING_DEPTH; i++) begin
            ring_pos[i] <= '0;
            ring_neg[i] <= '0;
         end
      end else begin
         if (dqs_rise) begin
            ring_pos[cap_ptr] <= to_core;
         end
         if (dqs_fall) begin
            ring_neg[cap_ptr] <= to_core;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read back
   ////////////////////////////////////////////////////////////////////////////

   // Count c reads entry c-1, so count 0 wraps to entry 3
   assign pos_sel = pos_cnt - ring_ptr_t'(1);
   assign neg_sel = neg_cnt - ring_ptr_t'(1);

   // Retimed to clk every cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_result <= '0;
      end else begin
         rd_result.data_in_hi <= ring_pos[pos_sel];
         rd_result.data_in    <= ring_neg[neg_sel];
      end
   end

endmodule

//--- hw/dq_lane_pkg.sv
package dq_lane_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Lane constants
   ////////////////////////////////////////////////////////////////////////////

   // One DQ lane carries a single byte per beat
   localparam int LANE_BITS = 8;

   // Capture pointer width and the ring depth it addresses
   localparam int PTR_BITS   = 2;
   localparam int RING_DEPTH = 1 << PTR_BITS;

   // One beat of pad data
   typedef logic [LANE_BITS-1:0] lane_byte_t;

   // Capture pointer, also used for the core read counts
   typedef logic [PTR_BITS-1:0] ring_ptr_t;

   ////////////////////////////////////////////////////////////////////////////
   // Drive word, seen two ways
   ////////////////////////////////////////////////////////////////////////////

   // Functional view, rising and falling phase bytes
   typedef struct packed {
      lane_byte_t data_pos;
      lane_byte_t data_neg;
   } drive_norm_t;

   // Test view, pad override byte and output type
   typedef struct packed {
      lane_byte_t afo;
      logic       tp_out_type;
      logic [6:0] unused;
   } drive_test_t;

   // Same 16 bits, decoded by test_mode in the write path
   typedef union packed {
      drive_norm_t norm;
      drive_test_t test;
   } pad_drive_u;

   // Registered read result handed to the core
   typedef struct packed {
      lane_byte_t data_in_hi;
      lane_byte_t data_in;
   } rd_result_t;

endpackage

//--- hw/dq_lane_top.sv
`timescale 1ns/100ps

module dq_lane_top (
   input  logic                    clk,
   input  logic                    rst,

   // Write side from the controller
   input  dq_lane_pkg::pad_drive_u  pad_drive,
   input  logic                    dqs_phase,
   input  logic                    drive_enable,
   input  logic                    test_mode,

   // Read side, pad byte and DQS qualifiers
   input  dq_lane_pkg::lane_byte_t  to_core,
   input  logic                    dqs_rise,
   input  logic                    dqs_fall,
   input  logic                    pad_enable,
   input  logic                    ptr_clk_inv,
   input  logic                    burst_length_four,
   input  dq_lane_pkg::ring_ptr_t   pos_cnt,
   input  dq_lane_pkg::ring_ptr_t   neg_cnt,

   // Pad side
   output dq_lane_pkg::lane_byte_t  to_pad,
   output logic                    oe,

   // Core side
   output dq_lane_pkg::rd_result_t  rd_result,
   output dq_lane_pkg::lane_byte_t  afi
);

   // Window from the enable shaper into the capture pointer
   logic rd_window;

   ////////////////////////////////////////////////////////////////////////////
   // Read path
   ////////////////////////////////////////////////////////////////////////////

   dq_pad_enable_gen dq_pad_enable_gen_i (
      .clk         (clk),
      .rst         (rst),
      .pad_enable  (pad_enable),
      .ptr_clk_inv (ptr_clk_inv),
      .rd_window   (rd_window)
   );

   dq_capture_ring dq_capture_ring_i (
      .clk               (clk),
      .rst               (rst),
      .to_core           (to_core),
      .dqs_rise          (dqs_rise),
      .dqs_fall          (dqs_fall),
      .rd_window         (rd_window),
      .burst_length_four (burst_length_four),
      .pos_cnt           (pos_cnt),
      .neg_cnt           (neg_cnt),
      .rd_result         (rd_result)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Write path and test override
   ////////////////////////////////////////////////////////////////////////////

   dq_write_path dq_write_path_i (
      .clk          (clk),
      .rst          (rst),
      .pad_drive    (pad_drive),
      .dqs_phase    (dqs_phase),
      .drive_enable (drive_enable),
      .test_mode    (test_mode),
      .to_core      (to_core),
      .to_pad       (to_pad),
      .oe           (oe),
      .afi          (afi)
   );

endmodule

//--- hw/dq_pad_enable_gen.sv
`timescale 1ns/100ps

module dq_pad_enable_gen (
   input  logic clk,
   input  logic rst,
   // Pad enable from the memory controller
   input  logic pad_enable,
   // Selects late placement of the window
   input  logic ptr_clk_inv,
   // Window that qualifies capture pointer movement
   output logic rd_window
);

   ////////////////////////////////////////////////////////////////////////////
   // Pad enable delay chain
   ////////////////////////////////////////////////////////////////////////////

   // Three stages, E1 is the newest
   logic pad_en_d1;
   logic pad_en_d2;
   logic pad_en_d3;

   // Early and late window candidates
   logic win_early;
   logic win_late;

   always_ff @(posedge clk) begin
      if (rst) begin
         pad_en_d1 <= 1'b0;
         pad_en_d2 <= 1'b0;
         pad_en_d3 <= 1'b0;
      end else begin
         pad_en_d1 <= pad_enable;
         pad_en_d2 <= pad_en_d1;
         pad_en_d3 <= pad_en_d2;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Window shaping
   ////////////////////////////////////////////////////////////////////////////

   // OR of adjacent stages stretches a one-cycle pulse to two cycles
   assign win_early = pad_en_d1 | pad_en_d2;
   // Late window trails by one more cycle
   assign win_late  = pad_en_d2 | pad_en_d3;

   // Stand-in for the half-cycle shift of the pointer clock
   always_comb begin
      if (ptr_clk_inv) begin
         rd_window = win_late;
      end else begin
         rd_window = win_early;
      end
   end

endmodule

//--- hw/dq_write_path.sv
`timescale 1ns/100ps

module dq_write_path (
   input  logic                   clk,
   input  logic                   rst,
   // Drive word, functional or test view
   input  dq_lane_pkg::pad_drive_u pad_drive,
   // Picks the falling phase byte when high
   input  logic                   dqs_phase,
   input  logic                   drive_enable,
   input  logic                   test_mode,
   // Pad input, looped back in test mode
   input  dq_lane_pkg::lane_byte_t to_core,
   output dq_lane_pkg::lane_byte_t to_pad,
   output logic                   oe,
   output dq_lane_pkg::lane_byte_t afi
);

   import dq_lane_pkg::*;

   // Registered drive word
   pad_drive_u drive_d1;

   // Two enable stages
   logic enable_q;
   logic enable_data;

   ////////////////////////////////////////////////////////////////////////////
   // Write registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         drive_d1    <= '0;
         enable_q    <= 1'b0;
         enable_data <= 1'b0;
      end else begin
         drive_d1    <= pad_drive;
         enable_q    <= drive_enable;
         enable_data <= enable_q;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Pad outputs
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      if (test_mode) begin
         // Test view overrides data and output type
         to_pad = drive_d1.test.afo;
         oe     = drive_d1.test.tp_out_type;
      end else begin
         to_pad = dqs_phase ? drive_d1.norm.data_neg : drive_d1.norm.data_pos;
         // Overlap only, so a single-cycle request never drives
         oe     = enable_q & enable_data;
      end
   end

   // Pad input reaches the core only under test
   assign afi = test_mode ? to_core : '0;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the DQ lane testbench with Verilator and run it; a nonzero exit marks failure
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -f verilog.f --top-module dq_lane_tb -o dq_lane_sim \
   && ./obj_dir/dq_lane_sim \
   || { echo "Simulation run did not pass"; exit 1; }

//--- sim/dq_lane_chk.sv
`timescale 1ns/100ps

module dq_lane_chk (
   input logic                   clk,
   input logic                   rst,
   input logic                   test_mode,
   input logic                   drive_enable,
   input logic                   oe,
   input dq_lane_pkg::lane_byte_t afi,
   input logic                   dqs_fall,
   // Capture pointer inside the ring
   input dq_lane_pkg::ring_ptr_t  cap_ptr
);

   // Pad input reaches the core only in test mode
   afi_gated: assert property (@(posedge clk) disable iff (rst) !test_mode |-> afi == '0)
      else $error("afi not zero with test_mode low");

   // Functional oe needs two past cycles of request
   oe_overlap: assert property (@(posedge clk) disable iff (rst)
      (!test_mode && oe) |-> ($past(drive_enable, 1) && $past(drive_enable, 2)))
      else $error("oe high without two cycles of drive_enable");

   // Pointer moves on the falling strobe only
   ptr_hold: assert property (@(posedge clk) disable iff (rst) !dqs_fall |=> $stable(cap_ptr))
      else $error("capture pointer moved without dqs_fall");

endmodule

bind dq_lane_top dq_lane_chk dq_lane_chk_i (
   .clk          (clk),
   .rst          (rst),
   .test_mode    (test_mode),
   .drive_enable (drive_enable),
   .oe           (oe),
   .afi          (afi),
   .dqs_fall     (dqs_fall),
   .cap_ptr      (dq_capture_ring_i.cap_ptr)
);

//--- sim/dq_lane_tb.sv
`timescale 1ns/100ps

module dq_lane_tb;

   import dq_lane_pkg::*;

   localparam int CLK_PERIOD  = 4;
   // Reset, write, enable, override, burst four, burst eight
   localparam int TEST_CYCLES = 5 + 16 + 11 + 9 + 26 + 46;

   logic        clk, rst;
   pad_drive_u  pad_drive;
   logic        dqs_phase, drive_enable, test_mode;
   logic        dqs_rise, dqs_fall, pad_enable, ptr_clk_inv, burst_length_four;
   lane_byte_t  to_core, to_pad, afi;
   ring_ptr_t   pos_cnt, neg_cnt;
   logic        oe;
   rd_result_t  rd_result;

   // Expected ring contents and pointer
   lane_byte_t  exp_pos [RING_DEPTH];
   lane_byte_t  exp_neg [RING_DEPTH];
   ring_ptr_t   exp_ptr;
   // Pad enable history, bit 0 is last cycle
   logic [2:0]  pe_hist;
   logic [15:0] lfsr;

   dq_lane_top dq_lane_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Galois LFSR, one step per bit taken
   function automatic logic lfsr_bit();
      logic lsb;
      lsb  = lfsr[0];
      lfsr = lsb ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      return lsb;
   endfunction

   function automatic lane_byte_t rand_byte();
      lane_byte_t b;
      for (int i = 0; i < LANE_BITS; i++)
         b[i] = lfsr_bit();
      return b;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Failure and compares
   ////////////////////////////////////////////////////////////////////////////

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "Run stopped on the first error");
   endtask

   task automatic check_byte(input string name, input lane_byte_t exp, input lane_byte_t act);
      if (act !== exp)
         fail_run($sformatf("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act));
   endtask

   task automatic check_result(input string name, input rd_result_t exp, input rd_result_t act);
      if (act !== exp)
         fail_run($sformatf("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         fail_run($sformatf("FAILED t=%0t %s expected %b actual %b", $time, name, exp, act));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Read side stimulus and reference
   ////////////////////////////////////////////////////////////////////////////

   // One read cycle, expected state follows the capture rules
   task automatic read_cycle(input logic rise, input logic fall, input logic pe);
      lane_byte_t b;
      logic       win;
      logic       moves;
      b = rand_byte();
      @(posedge clk);
      dqs_rise   <= rise;
      dqs_fall   <= fall;
      pad_enable <= pe;
      to_core    <= b;
      // Early window is E1 or E2, late is E2 or E3
      win   = ptr_clk_inv ? (pe_hist[1] | pe_hist[2]) : (pe_hist[0] | pe_hist[1]);
      moves = fall && (win || (burst_length_four ? exp_ptr[0] : (exp_ptr != '0)));
      if (rise)
         exp_pos[exp_ptr] = b;
      if (fall)
         exp_neg[exp_ptr] = b;
      if (moves)
         exp_ptr = exp_ptr + ring_ptr_t'(1);
      pe_hist = {pe_hist[1:0], pe};
   endtask

   // Mode change in a cycle with no strobes
   task automatic set_mode(input logic burst_four, input logic late);
      read_cycle(1'b0, 1'b0, 1'b0);
      burst_length_four <= burst_four;
      ptr_clk_inv       <= late;
   endtask

   // All 16 count pairs, result trails the counts by a cycle
   task automatic readout_test();
      rd_result_t exp;
      for (int i = 0; i <= 16; i++) begin
         read_cycle(1'b0, 1'b0, 1'b0);
         pos_cnt <= ring_ptr_t'(i / 4);
         neg_cnt <= ring_ptr_t'(i % 4);
         @(negedge clk);
         if (i > 0) begin
            // Count c names entry (c - 1) mod 4
            exp.data_in_hi = exp_pos[((i - 1) / 4 + 3) % 4];
            exp.data_in    = exp_neg[((i - 1) % 4 + 3) % 4];
            check_result("rd_result", exp, rd_result);
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic write_data_test();
      pad_drive_u word;
      pad_drive_u prev;
      prev = '0;
      for (int i = 0; i < 16; i++) begin
         word.norm.data_pos = rand_byte();
         word.norm.data_neg = rand_byte();
         @(posedge clk);
         pad_drive <= word;
         dqs_phase <= i[0];
         @(negedge clk);
         // Phase select acts on the word of the cycle before
         if (i > 0)
            check_byte("to_pad", i[0] ? prev.norm.data_neg : prev.norm.data_pos, to_pad);
         prev = word;
      end
   endtask

   task automatic oe_timing_test(input int high_cycles);
      logic en;
      logic en_d1;
      logic en_d2;
      en_d1 = 1'b0;
      en_d2 = 1'b0;
      for (int i = 0; i < high_cycles + 3; i++) begin
         en = (i < high_cycles);
         @(posedge clk);
         drive_enable <= en;
         @(negedge clk);
         // Drives only while both past requests overlap
         check_bit("oe", en_d1 & en_d2, oe);
         en_d2 = en_d1;
         en_d1 = en;
      end
   endtask

   task automatic test_override_test();
      pad_drive_u word;
      pad_drive_u prev;
      lane_byte_t core_b;
      prev = '0;
      for (int i = 0; i < 8; i++) begin
         word.test.afo         = rand_byte();
         word.test.tp_out_type = lfsr_bit();
         word.test.unused      = '0;
         core_b                = rand_byte();
         @(posedge clk);
         test_mode <= 1'b1;
         pad_drive <= word;
         to_core   <= core_b;
         @(negedge clk);
         check_byte("afi", core_b, afi);
         if (i > 0) begin
            check_byte("to_pad", prev.test.afo, to_pad);
            check_bit("oe", prev.test.tp_out_type, oe);
         end
         prev = word;
      end
      @(posedge clk);
      test_mode <= 1'b0;
      pad_drive <= '0;
      @(negedge clk);
      check_byte("afi", '0, afi);
   endtask

   // Pulse opens an early window, pointer stops on an even entry
   task automatic burst_four_test();
      read_cycle(1'b0, 1'b0, 1'b1);
      for (int i = 0; i < 4; i++) begin
         read_cycle(1'b1, 1'b0, 1'b0);
         read_cycle(1'b0, 1'b1, 1'b0);
      end
      readout_test();
   endtask

   task automatic burst_eight_test();
      set_mode(1'b0, 1'b0);
      // Runs on from a nonzero pointer until the wrap
      for (int i = 0; i < 3; i++) begin
         read_cycle(1'b1, 1'b0, 1'b0);
         read_cycle(1'b0, 1'b1, 1'b0);
      end
      readout_test();
      // Late window misses the fall right after the pulse
      set_mode(1'b0, 1'b1);
      read_cycle(1'b1, 1'b0, 1'b1);
      read_cycle(1'b0, 1'b1, 1'b0);
      read_cycle(1'b1, 1'b0, 1'b0);
      read_cycle(1'b0, 1'b1, 1'b0);
      readout_test();
   endtask

   initial begin
      lfsr    = 16'd68;
      exp_ptr = '0;
      pe_hist = '0;
      exp_pos = '{default: '0};
      exp_neg = '{default: '0};
      rst <= 1'b1;
      pad_drive <= '0;
      to_core <= '0;
      {dqs_phase, drive_enable, test_mode} <= '0;
      {dqs_rise, dqs_fall, pad_enable, ptr_clk_inv} <= '0;
      burst_length_four <= 1'b1;
      {pos_cnt, neg_cnt} <= '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      write_data_test();
      oe_timing_test(4);
      oe_timing_test(1);
      test_override_test();
      burst_four_test();
      burst_eight_test();
      $display("Finished with no errors");
      $finish;
   end

   // Watchdog, test length plus margin
   initial begin
      #(CLK_PERIOD * (TEST_CYCLES + 100));
      fail_run("Watchdog timeout, the tests did not finish in time");
   end

endmodule

//--- verilog.f
hw/dq_lane_pkg.sv
hw/dq_pad_enable_gen.sv
hw/dq_capture_ring.sv
hw/dq_write_path.sv
hw/dq_lane_top.sv
sim/dq_lane_chk.sv
sim/dq_lane_tb.sv
